// File: bridgePkg.sv
/* Shared types and constants of the 1553/SPI command core.
 * Command codes must match the host link's deframer.
 * Every queue in the core has the same depth, FifoDepth, which must be a power of two.
 */
`default_nettype none

package bridgePkg;

	localparam int FifoDepth = 16;	// words per queue
	localparam int PtrWidth = $clog2(FifoDepth);
	localparam int CountWidth = $clog2(FifoDepth + 1);	// holds 0..FifoDepth

	typedef logic [15:0] milWordT;	// one bus or host data word
	typedef logic [7:0] addrT;	// block address in headers
	typedef logic [15:0] cmdCodeT;
	typedef logic [15:0] sizeT;	// word count in headers
	typedef logic [CountWidth-1:0] countT;	// queue fill level
	typedef logic [PtrWidth-1:0] ptrT;	// queue read/write index

	localparam addrT ChanAddr0 = 8'hAB;
	localparam addrT ChanAddr1 = 8'hAC;

	// host protocol command codes
	localparam cmdCodeT CmdReset = 16'hA0A0;
	localparam cmdCodeT CmdSendData = 16'hA1A1;
	localparam cmdCodeT CmdReceiveSts = 16'hA2A2;
	localparam cmdCodeT CmdReceiveData = 16'hA3A3;
	localparam cmdCodeT CmdUnknown = 16'hFFFF;	// echoed for unmatched headers

	localparam sizeT StatusSize = 2;	// rx fill level, then tx fill level

	typedef enum logic [2:0] {
		KindNone,
		KindSend,
		KindRecvData,
		KindRecvSts,
		KindReset
	} cmdKindT;

	typedef enum logic [2:0] {
		Idle,
		HdrAddr,
		HdrCmd,
		HdrSize,
		Body
	} replyStateT;

endpackage

`default_nettype wire

// File: wordFifo.sv
/* First-word-fall-through queue of FifoDepth words.
 * A push to a full queue is dropped. Push and pop may share a cycle.
 * A pop while empty is a caller error and leaves the queue unchanged.
 */
`default_nettype none

module wordFifo (
	input logic clk,
	input logic rstN,
	input logic push,
	input bridgePkg::milWordT pushWord,
	input logic pop,
	output bridgePkg::milWordT head,
	output bridgePkg::countT used,
	output logic empty,
	output logic full
);

	import bridgePkg::*;

	milWordT mem [FifoDepth];
	ptrT rdPtr;
	ptrT wrPtr;
	countT count;
	logic doPush;
	logic doPop;

	assign empty = (count == '0);
	assign full = (count == countT'(FifoDepth));
	assign used = count;
	assign head = mem[rdPtr];	// valid whenever not empty

	assign doPush = push && !full;	// full queue drops the word
	assign doPop = pop && !empty;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps, depth is a power of two
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushWord;
	end

	// readers outside must track the fill level they were given
	assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("wordFifo: pop while empty");

	assert property (@(posedge clk) disable iff (!rstN) used <= countT'(FifoDepth))
		else $error("wordFifo: fill level above depth");

endmodule

`default_nettype wire

// File: channelPath.sv
/* One bus channel: receive queue toward the host, transmit queue toward the bus.
 * The pacer sends a word only while milTxBusy is low, then skips one cycle
 * so the transmitter has time to raise busy.
 */
`default_nettype none

module channelPath (
	input logic clk,
	input logic rstN,
	input logic milRxValid,
	input bridgePkg::milWordT milRxWord,
	input logic txPush,
	input bridgePkg::milWordT txWord,
	input logic rxPop,
	input logic milTxBusy,
	output logic milTxValid,
	output bridgePkg::milWordT milTxWord,
	output bridgePkg::milWordT rxHead,
	output bridgePkg::countT rxUsed,
	output bridgePkg::countT txUsed
);

	import bridgePkg::*;

	milWordT txHead;
	logic txEmpty;
	logic txPop;
	logic pending;	// a word went out last cycle

	// words received from the bus, drained by the reply builder
	wordFifo u_rxFifo (
		.clk(clk),
		.rstN(rstN),
		.push(milRxValid),
		.pushWord(milRxWord),
		.pop(rxPop),
		.head(rxHead),
		.used(rxUsed),
		.empty(),
		.full()
	);

	// host words waiting for the bus transmitter
	wordFifo u_txFifo (
		.clk(clk),
		.rstN(rstN),
		.push(txPush),
		.pushWord(txWord),
		.pop(txPop),
		.head(txHead),
		.used(txUsed),
		.empty(txEmpty),
		.full()
	);

	assign txPop = !txEmpty && !pending && !milTxBusy;
	assign milTxValid = txPop;	// strobe and pop together
	assign milTxWord = txHead;

	always_ff @(posedge clk) begin
		if (!rstN)
			pending <= 1'b0;
		else
			pending <= txPop;	// hold off for one cycle after a send
	end

	// transmitter owns the line while busy
	assert property (@(posedge clk) disable iff (!rstN) milTxValid |-> !milTxBusy)
		else $error("channelPath: send while transmitter busy");

endmodule

`default_nettype wire

// File: cmdDecode.sv
/* Header decode and host data steering.
 * Headers are taken only while cmdBusy is low, others are dropped.
 * RESET is honoured on ChanAddr0 only. Unknown address or code is ignored.
 */
`default_nettype none

module cmdDecode (
	input logic clk,
	input logic rstN,
	input logic hdrValid,
	input bridgePkg::addrT hdrAddr,
	input bridgePkg::cmdCodeT hdrCmd,
	input bridgePkg::sizeT hdrSize,
	input logic hostWordValid,
	input bridgePkg::milWordT hostWord,
	input logic replyDone,
	output logic cmdStart,
	output bridgePkg::cmdKindT cmdKind,
	output logic cmdChan,
	output bridgePkg::addrT cmdAddr,
	output bridgePkg::cmdCodeT cmdCode,
	output bridgePkg::sizeT reqSize,
	output logic [1:0] txPush,
	output bridgePkg::milWordT txWord,
	output logic cmdBusy,
	output logic resetReq
);

	import bridgePkg::*;

	logic accept;
	logic [5:0] hit;	// {recvData, recvSts, send, reset, chan1, chan0}
	cmdKindT hdrKind;
	logic hdrChan;
	sizeT wordsLeft;	// SEND_DATA words still expected

	assign accept = hdrValid && !cmdBusy;

	assign hit[0] = (hdrAddr == ChanAddr0);
	assign hit[1] = (hdrAddr == ChanAddr1);
	assign hit[2] = (hdrCmd == CmdReset);
	assign hit[3] = (hdrCmd == CmdSendData);
	assign hit[4] = (hdrCmd == CmdReceiveSts);
	assign hit[5] = (hdrCmd == CmdReceiveData);

	always_comb begin
		hdrKind = KindNone;
		hdrChan = 1'b0;
		case (hit)
			6'b100001: hdrKind = KindRecvData;
			6'b010001: hdrKind = KindRecvSts;
			6'b001001: hdrKind = KindSend;
			6'b000101: hdrKind = KindReset;	// channel 1 reset falls to default
			6'b100010: begin
				hdrKind = KindRecvData;
				hdrChan = 1'b1;
			end
			6'b010010: begin
				hdrKind = KindRecvSts;
				hdrChan = 1'b1;
			end
			6'b001010: begin
				hdrKind = KindSend;
				hdrChan = 1'b1;
			end
			default: hdrKind = KindNone;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cmdStart <= 1'b0;
			cmdKind <= KindNone;
			cmdBusy <= 1'b0;
			resetReq <= 1'b0;
			txPush <= '0;
			wordsLeft <= '0;
		end else begin
			cmdStart <= accept && (hdrKind != KindNone);
			resetReq <= accept && (hdrKind == KindReset);
			txPush <= '0;
			if (accept) begin
				cmdKind <= hdrKind;
				wordsLeft <= hdrSize;
				case (hdrKind)
					KindSend: cmdBusy <= (hdrSize != '0);	// empty send frees at once
					KindRecvData, KindRecvSts: cmdBusy <= 1'b1;
					default: cmdBusy <= 1'b0;
				endcase
			end else if (cmdBusy) begin
				if (cmdKind == KindSend && hostWordValid) begin
					txPush[cmdChan] <= 1'b1;
					wordsLeft <= wordsLeft - 1'b1;
					if (wordsLeft == sizeT'(1))
						cmdBusy <= 1'b0;
				end
				if (replyDone)
					cmdBusy <= 1'b0;	// reply builder sent its last word
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmdChan <= hdrChan;
			cmdAddr <= hdrAddr;
			cmdCode <= (hdrKind == KindNone) ? CmdUnknown : hdrCmd;
			reqSize <= hdrSize;
		end
		if (hostWordValid)
			txWord <= hostWord;
	end

	// host data goes to a single channel at a time
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(txPush))
		else $error("cmdDecode: push to both channels");

endmodule

`default_nettype wire

// File: replyBuilder.sv
/* Reply stream for RECEIVE_DATA and RECEIVE_STS.
 * Three header words (address, code, size) then the body, one word per cycle.
 * No back-pressure on the host side. Data size is capped by rxUsed at cmdStart.
 */
`default_nettype none

module replyBuilder (
	input logic clk,
	input logic rstN,
	input logic cmdStart,
	input bridgePkg::cmdKindT cmdKind,
	input logic cmdChan,
	input bridgePkg::addrT cmdAddr,
	input bridgePkg::cmdCodeT cmdCode,
	input bridgePkg::sizeT reqSize,
	input bridgePkg::milWordT rxHead [2],
	input bridgePkg::countT rxUsed [2],
	input bridgePkg::countT txUsed [2],
	output logic [1:0] rxPop,
	output logic replyValid,
	output bridgePkg::milWordT replyWord,
	output logic replyLast,
	output logic replyDone
);

	import bridgePkg::*;

	replyStateT state;
	logic isData;	// body comes from the rx queue
	logic chan;
	cmdCodeT code;
	sizeT bodyLeft;	// body words not yet loaded
	countT stsRx;
	countT stsTx;
	sizeT rxAvail;
	sizeT dataSize;
	logic startReply;
	logic loadBody;

	assign rxAvail = sizeT'(rxUsed[cmdChan]);
	assign dataSize = (reqSize < rxAvail) ? reqSize : rxAvail;
	assign startReply = (state == Idle) && cmdStart &&
		(cmdKind == KindRecvData || cmdKind == KindRecvSts);

	assign loadBody = (state == HdrSize || state == Body) && (bodyLeft != '0);
	assign rxPop[0] = loadBody && isData && !chan;	// head is taken this cycle
	assign rxPop[1] = loadBody && isData && chan;
	assign replyDone = replyValid && replyLast;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= Idle;
			replyValid <= 1'b0;
			replyLast <= 1'b0;
			bodyLeft <= '0;
		end else begin
			case (state)
				Idle: begin
					if (startReply) begin
						state <= HdrAddr;
						replyValid <= 1'b1;
						bodyLeft <= (cmdKind == KindRecvData) ? dataSize : StatusSize;
					end
				end
				HdrAddr: state <= HdrCmd;
				HdrCmd: begin
					state <= HdrSize;
					replyLast <= (bodyLeft == '0);	// header-only reply
				end
				HdrSize, Body: begin
					if (loadBody) begin
						state <= Body;
						bodyLeft <= bodyLeft - 1'b1;
						replyLast <= (bodyLeft == sizeT'(1));
					end else begin
						state <= Idle;
						replyValid <= 1'b0;
						replyLast <= 1'b0;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (startReply) begin
			isData <= (cmdKind == KindRecvData);
			chan <= cmdChan;
			code <= cmdCode;
			stsRx <= rxUsed[cmdChan];	// status is a snapshot at start
			stsTx <= txUsed[cmdChan];
		end
		case (state)
			Idle: replyWord <= {8'h00, cmdAddr};
			HdrAddr: replyWord <= code;
			HdrCmd: replyWord <= bodyLeft;
			default: begin
				if (loadBody) begin
					if (isData)
						replyWord <= rxHead[chan];
					else
						replyWord <= milWordT'((bodyLeft == StatusSize) ? stsRx : stsTx);
				end
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (!rstN) replyLast |-> replyValid)
		else $error("replyBuilder: last flag outside a reply word");

endmodule

`default_nettype wire

// File: bridgeCore.sv
/* Command core of the two-channel 1553/SPI bridge.
 * Host header and data arrive deframed. Replies have no back-pressure.
 * Index n of each bus array belongs to channel n (ChanAddr0, ChanAddr1).
 */
`default_nettype none

module bridgeCore (
	input logic clk,
	input logic rstN,
	input logic hdrValid,
	input bridgePkg::addrT hdrAddr,
	input bridgePkg::cmdCodeT hdrCmd,
	input bridgePkg::sizeT hdrSize,
	input logic hostWordValid,
	input bridgePkg::milWordT hostWord,
	output logic replyValid,
	output bridgePkg::milWordT replyWord,
	output logic replyLast,
	output logic cmdBusy,
	output logic resetReq,
	input logic [1:0] milRxValid,
	input bridgePkg::milWordT milRxWord [2],
	output logic [1:0] milTxValid,
	output bridgePkg::milWordT milTxWord [2],
	input logic [1:0] milTxBusy
);

	import bridgePkg::*;

	logic cmdStart;
	cmdKindT cmdKind;
	logic cmdChan;
	addrT cmdAddr;
	cmdCodeT cmdCode;
	sizeT reqSize;
	logic [1:0] txPush;
	milWordT txWord;
	logic [1:0] rxPop;
	logic replyDone;
	milWordT rxHead [2];
	countT rxUsed [2];
	countT txUsed [2];

	cmdDecode u_decode (
		.clk(clk),
		.rstN(rstN),
		.hdrValid(hdrValid),
		.hdrAddr(hdrAddr),
		.hdrCmd(hdrCmd),
		.hdrSize(hdrSize),
		.hostWordValid(hostWordValid),
		.hostWord(hostWord),
		.replyDone(replyDone),
		.cmdStart(cmdStart),
		.cmdKind(cmdKind),
		.cmdChan(cmdChan),
		.cmdAddr(cmdAddr),
		.cmdCode(cmdCode),
		.reqSize(reqSize),
		.txPush(txPush),
		.txWord(txWord),
		.cmdBusy(cmdBusy),
		.resetReq(resetReq)
	);

	for (genvar ch = 0; ch < 2; ch++) begin : gChan
		channelPath u_chan (
			.clk(clk),
			.rstN(rstN),
			.milRxValid(milRxValid[ch]),
			.milRxWord(milRxWord[ch]),
			.txPush(txPush[ch]),
			.txWord(txWord),	// shared, txPush selects the channel
			.rxPop(rxPop[ch]),
			.milTxBusy(milTxBusy[ch]),
			.milTxValid(milTxValid[ch]),
			.milTxWord(milTxWord[ch]),
			.rxHead(rxHead[ch]),
			.rxUsed(rxUsed[ch]),
			.txUsed(txUsed[ch])
		);
	end

	replyBuilder u_reply (
		.clk(clk),
		.rstN(rstN),
		.cmdStart(cmdStart),
		.cmdKind(cmdKind),
		.cmdChan(cmdChan),
		.cmdAddr(cmdAddr),
		.cmdCode(cmdCode),
		.reqSize(reqSize),
		.rxHead(rxHead),
		.rxUsed(rxUsed),
		.txUsed(txUsed),
		.rxPop(rxPop),
		.replyValid(replyValid),
		.replyWord(replyWord),
		.replyLast(replyLast),
		.replyDone(replyDone)
	);

endmodule

`default_nettype wire

// File: tbBridgeCore.sv
/* Testbench for bridgeCore with reference queues for both channels.
 * Status replies are only requested while the transmitter model holds busy,
 * so the transmit fill level is stable. Sends with the queue draining stay below capacity.
 */
`default_nettype none

module tbBridgeCore;
	timeunit 1ns;
	timeprecision 100ps;

	import bridgePkg::*;

	localparam int NumCmds = 60;
	localparam int WatchCycles = NumCmds * 200 + 2000;

	logic clk;
	logic rstN;
	logic hdrValid;
	addrT hdrAddr;
	cmdCodeT hdrCmd;
	sizeT hdrSize;
	logic hostWordValid;
	milWordT hostWord;
	logic replyValid;
	milWordT replyWord;
	logic replyLast;
	logic cmdBusy;
	logic resetReq;
	logic [1:0] milRxValid;
	milWordT milRxWord [2];
	logic [1:0] milTxValid;
	milWordT milTxWord [2];
	logic [1:0] milTxBusy;

	milWordT rxq [2][$];	// reference receive queues
	milWordT txq [2][$];	// reference transmit queues
	milWordT expQ [$];	// expected reply words
	bit expIsCount [$];
	bit txHold;	// transmitter model holds busy
	int busyLeft [2];
	bit strobeSeen [2];	// a word went out at the last rising edge
	int resetPulses;
	int expResets;

	bridgeCore u_dut (
		.clk(clk),
		.rstN(rstN),
		.hdrValid(hdrValid),
		.hdrAddr(hdrAddr),
		.hdrCmd(hdrCmd),
		.hdrSize(hdrSize),
		.hostWordValid(hostWordValid),
		.hostWord(hostWord),
		.replyValid(replyValid),
		.replyWord(replyWord),
		.replyLast(replyLast),
		.cmdBusy(cmdBusy),
		.resetReq(resetReq),
		.milRxValid(milRxValid),
		.milRxWord(milRxWord),
		.milTxValid(milTxValid),
		.milTxWord(milTxWord),
		.milTxBusy(milTxBusy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(input string name, input milWordT exp, input milWordT act);
		if (act !== exp)
			stopOnError($sformatf("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkCount(input string name, input countT exp, input countT act);
		if (act !== exp)
			stopOnError($sformatf("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stopOnError($sformatf("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	function automatic int chanOf(input addrT a);
		if (a == ChanAddr0)
			return 0;
		if (a == ChanAddr1)
			return 1;
		return -1;	// not ours
	endfunction

	function automatic void addExpected(input milWordT w, input bit isCount);
		expQ.push_back(w);
		expIsCount.push_back(isCount);
	endfunction

	// expected reply for a header, taken from the reference queues at header time
	function automatic void buildReply(input addrT a, input cmdCodeT c, input sizeT s);
		int ch;
		int n;
		ch = chanOf(a);
		if (ch < 0)
			return;
		if (c == CmdReceiveData) begin
			n = (int'(s) < rxq[ch].size()) ? int'(s) : rxq[ch].size();
			addExpected({8'h00, a}, 1'b0);
			addExpected(c, 1'b0);
			addExpected(milWordT'(n), 1'b0);
			for (int i = 0; i < n; i++)
				addExpected(rxq[ch].pop_front(), 1'b0);
		end else if (c == CmdReceiveSts) begin
			addExpected({8'h00, a}, 1'b0);
			addExpected(c, 1'b0);
			addExpected(milWordT'(2), 1'b0);
			addExpected(milWordT'(rxq[ch].size()), 1'b1);
			addExpected(milWordT'(txq[ch].size()), 1'b1);
		end
	endfunction

	// reply comparator
	always @(negedge clk) begin
		milWordT exp;
		bit isCount;
		if (rstN && replyValid) begin
			if (expQ.size() == 0) begin
				stopOnError("a reply word arrived when no reply was expected");
			end else begin
				exp = expQ.pop_front();
				isCount = expIsCount.pop_front();
				if (isCount) begin
					checkCount("replyWord", countT'(exp), countT'(replyWord));
					checkWord("replyWord upper bits", '0, replyWord >> CountWidth);
				end else begin
					checkWord("replyWord", exp, replyWord);
				end
				checkFlag("replyLast", expQ.size() == 0, replyLast);
			end
		end else if (rstN) begin
			checkFlag("replyLast", 1'b0, replyLast);
		end
		if (rstN && resetReq)
			resetPulses++;
	end

	// transmit strobes count at the rising edge where the DUT pops
	always @(posedge clk) begin
		for (int ch = 0; ch < 2; ch++) begin
			if (rstN && milTxValid[ch]) begin
				checkFlag("milTxBusy", 1'b0, milTxBusy[ch]);
				if (strobeSeen[ch])
					stopOnError("transmit strobes came on consecutive cycles");
				if (txq[ch].size() == 0)
					stopOnError("a word was transmitted with none queued");
				else
					checkWord("milTxWord", txq[ch].pop_front(), milTxWord[ch]);
			end
			strobeSeen[ch] = rstN && milTxValid[ch];
		end
	end

	// transmitter model raises busy one cycle late and holds it 1 to 4 cycles
	initial begin
		milTxBusy = '0;
		forever begin
			@(negedge clk);
			for (int ch = 0; ch < 2; ch++) begin
				if (busyLeft[ch] > 0) begin
					milTxBusy[ch] = 1'b1;
					busyLeft[ch]--;
				end else begin
					milTxBusy[ch] = txHold;
				end
				if (strobeSeen[ch])
					busyLeft[ch] = $urandom_range(1, 4);
			end
		end
	end

	initial begin
		repeat (WatchCycles) @(posedge clk);
		stopOnError("timeout: the run did not finish in the expected number of cycles");
	end

	task automatic injectRx(input int ch, input int n);
		milWordT w;
		for (int i = 0; i < n; i++) begin
			w = milWordT'($urandom);
			milRxValid[ch] = 1'b1;
			milRxWord[ch] = w;
			if (rxq[ch].size() < FifoDepth)
				rxq[ch].push_back(w);
			@(negedge clk);
		end
		milRxValid[ch] = 1'b0;
	endtask

	task automatic runCmd(input addrT a, input cmdCodeT c, input sizeT s);
		int ch;
		bit busyCmd;
		milWordT w;
		ch = chanOf(a);
		busyCmd = (ch >= 0) && ((c == CmdSendData && s != 0) || c == CmdReceiveData ||
			c == CmdReceiveSts);
		while (cmdBusy)
			@(negedge clk);
		hdrValid = 1'b1;
		hdrAddr = a;
		hdrCmd = c;
		hdrSize = s;
		buildReply(a, c, s);
		if (ch == 0 && c == CmdReset)
			expResets++;
		@(negedge clk);
		hdrValid = 1'b0;
		if (!busyCmd)
			checkFlag("cmdBusy", 1'b0, cmdBusy);
		if (ch >= 0 && c == CmdSendData) begin
			for (int i = 0; i < int'(s); i++) begin
				w = milWordT'($urandom);
				hostWordValid = 1'b1;
				hostWord = w;
				if (txq[ch].size() < FifoDepth)
					txq[ch].push_back(w);	// full queue drops
				@(negedge clk);
			end
			hostWordValid = 1'b0;
		end
		while (cmdBusy || expQ.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (resetPulses != expResets)
			stopOnError("resetReq pulse count differs from the expected count");
	endtask

	task automatic statusCmd(input addrT a);
		txHold = 1'b1;
		repeat (3) @(negedge clk);	// let the last strobe land
		runCmd(a, CmdReceiveSts, 0);
		txHold = 1'b0;
	endtask

	task automatic drainTx();
		while (txq[0].size() != 0 || txq[1].size() != 0)
			@(negedge clk);
		repeat (6) @(negedge clk);
	endtask

	initial begin
		int ch;
		int n;
		addrT a;
		void'($urandom(32'h970b938b));
		rstN = 1'b0;
		hdrValid = 1'b0;
		hdrAddr = '0;
		hdrCmd = '0;
		hdrSize = '0;
		hostWordValid = 1'b0;
		hostWord = '0;
		milRxValid = '0;
		milRxWord[0] = '0;
		milRxWord[1] = '0;
		txHold = 1'b0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		repeat (5) begin
			@(negedge clk);
			checkFlag("replyValid", 1'b0, replyValid);
			checkFlag("cmdBusy", 1'b0, cmdBusy);
			checkFlag("resetReq", 1'b0, resetReq);
			checkFlag("milTxValid[0]", 1'b0, milTxValid[0]);
			checkFlag("milTxValid[1]", 1'b0, milTxValid[1]);
		end
		statusCmd(ChanAddr0);
		statusCmd(ChanAddr1);

		// transmit path, then overflow with the transmitter stalled
		runCmd(ChanAddr0, CmdSendData, 8);
		runCmd(ChanAddr1, CmdSendData, 8);
		drainTx();
		txHold = 1'b1;
		repeat (3) @(negedge clk);
		runCmd(ChanAddr0, CmdSendData, 20);
		statusCmd(ChanAddr0);
		drainTx();

		// receive path, sizes below, equal to and above the fill level
		injectRx(1, 5);
		runCmd(ChanAddr1, CmdReceiveData, 3);
		statusCmd(ChanAddr1);
		runCmd(ChanAddr1, CmdReceiveData, 2);
		injectRx(1, 2);
		runCmd(ChanAddr1, CmdReceiveData, 6);
		statusCmd(ChanAddr1);

		// reset and ignored headers
		runCmd(ChanAddr0, CmdReset, 0);
		runCmd(ChanAddr1, CmdReset, 0);
		runCmd(ChanAddr0, 16'h1234, 4);
		runCmd(8'h55, CmdReceiveSts, 0);
		statusCmd(ChanAddr0);
		statusCmd(ChanAddr1);

		// mixed traffic on both channels
		for (int k = 0; k < 40; k++) begin
			ch = $urandom_range(0, 1);
			a = (ch == 1) ? ChanAddr1 : ChanAddr0;
			case ($urandom_range(0, 4))
				0: begin
					n = $urandom_range(1, 4);
					if (txq[ch].size() + n <= 13)	// margin for words in flight
						runCmd(a, CmdSendData, sizeT'(n));
					else
						runCmd(a, CmdReceiveData, 1);
				end
				1: begin
					injectRx(ch, $urandom_range(0, 3));
					runCmd(a, CmdReceiveData, sizeT'($urandom_range(0, 6)));
				end
				2: statusCmd(a);
				3: runCmd(a, 16'h5A5A, 3);
				default: runCmd(8'h3C, CmdReceiveSts, 0);
			endcase
		end
		drainTx();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
bridgePkg.sv
wordFifo.sv
channelPath.sv
cmdDecode.sv
replyBuilder.sv
bridgeCore.sv
tbBridgeCore.sv

// File: run.sh
#!/bin/sh
# Build and run the bridgeCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbBridgeCore -f all.f -o tbBridgeCore
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tbBridgeCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
